// ==== src/pool_defs.svh ====
`ifndef POOL_DEFS_SVH
`define POOL_DEFS_SVH

// Channels carried by every pixel of the feature map.
`define POOL_CHANNELS 4

// Width of one activation in bits.
`define POOL_ACTIV_BITS 8

// Input map size in pixels. Both values must be even for 2x2 pooling.
`define POOL_MAP_WIDTH 8
`define POOL_MAP_HEIGHT 4

`endif

// ==== src/pool_pkg.sv ====
`default_nettype none

`include "pool_defs.svh"

package pool_pkg;

    typedef logic [`POOL_ACTIV_BITS-1:0] activ_t;         // After ReLU.
    typedef logic signed [`POOL_ACTIV_BITS-1:0] sactiv_t; // As it arrives.

    // One raw input pixel, channel 0 in the low bits.
    typedef struct packed {
        sactiv_t [`POOL_CHANNELS-1:0] ch;
    } raw_pixel_t;

    typedef struct packed {
        activ_t [`POOL_CHANNELS-1:0] ch;
    } pixel_t;

    // The last bit marks the final pooled pixel of a map.
    typedef struct packed {
        logic   last;
        pixel_t pix;
    } pooled_t;

    // Index into the line buffer of pair maxima, one entry per pooled column.
    localparam int POOL_IDX_BITS =
        ($clog2(`POOL_MAP_WIDTH / 2) > 0) ? $clog2(`POOL_MAP_WIDTH / 2) : 1;

    typedef logic [POOL_IDX_BITS-1:0] buf_idx_t;

endpackage

`default_nettype wire

// ==== src/stream_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

// One-entry valid/ready register. A full entry that drains in the same
// cycle is refilled at once, so transfers can run every cycle.
module stream_reg #(
    parameter type payload_t = logic
) (
    input  wire logic     clk,
    input  wire logic     rst_n,

    input  wire logic     in_valid,
    output logic          in_ready,
    input  wire payload_t in_data,

    output logic          out_valid,
    input  wire logic     out_ready,
    output payload_t      out_data
);

    logic     full;
    payload_t data_q;

    assign in_ready  = !full || out_ready;
    assign out_valid = full;
    assign out_data  = data_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (in_valid && in_ready) begin
            full <= 1'b1;
        end else if (out_ready) begin
            full <= 1'b0;  // Drained with nothing behind it.
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

endmodule

`default_nettype wire

// ==== src/relu_clamp.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pool_defs.svh"

// Per-channel ReLU. Negative activations become zero, the rest pass
// unchanged, and the result is unsigned from here on.
module relu_clamp (
    input  wire pool_pkg::raw_pixel_t in_pixel,
    output pool_pkg::pixel_t          out_pixel
);

    import pool_pkg::*;

    genvar c;

    generate
        for (c = 0; c < `POOL_CHANNELS; c++) begin : g_ch
            sactiv_t s;

            assign s = in_pixel.ch[c];

            // A set sign bit marks a negative activation.
            assign out_pixel.ch[c] = s[`POOL_ACTIV_BITS-1] ? '0 : activ_t'(s);
        end
    endgenerate

endmodule

`default_nettype wire

// ==== src/pool_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pool_defs.svh"

// Raster position of the pixel held at the input, and the phase strobes
// that follow from it.
module pool_ctrl (
    input  wire logic           clk,
    input  wire logic           rst_n,

    input  wire logic           pix_valid,
    input  wire logic           out_ready,

    output logic                take,
    output logic                hold_pair,
    output logic                write_row,
    output logic                emit,
    output logic                last,
    output pool_pkg::buf_idx_t  col_index
);

    import pool_pkg::*;

    localparam int COL_BITS = $clog2(`POOL_MAP_WIDTH);
    localparam int ROW_BITS = $clog2(`POOL_MAP_HEIGHT);

    logic [COL_BITS-1:0] col;
    logic [ROW_BITS-1:0] row;
    logic                col_last;
    logic                row_last;
    logic                odd_col;
    logic                odd_row;
    logic                emit_phase;

    assign col_last = (col == COL_BITS'(`POOL_MAP_WIDTH - 1));
    assign row_last = (row == ROW_BITS'(`POOL_MAP_HEIGHT - 1));
    assign odd_col  = col[0];
    assign odd_row  = row[0];

    // Bottom-right pixel of a 2x2 window.
    assign emit_phase = odd_row && odd_col;

    // Only an emit needs room downstream. Every other phase consumes at once.
    assign take = pix_valid && (!emit_phase || out_ready);

    assign hold_pair = take && !odd_col;
    assign write_row = take && !odd_row && odd_col;

    // Offered whenever the window is complete. out_reg decides the transfer.
    assign emit = pix_valid && emit_phase;
    assign last = emit_phase && col_last && row_last;

    assign col_index = buf_idx_t'(col >> 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col <= '0;
            row <= '0;
        end else if (take) begin
            if (col_last) begin
                col <= '0;
                if (row_last) begin
                    row <= '0;  // Next map follows directly.
                end else begin
                    row <= row + 1'b1;
                end
            end else begin
                col <= col + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/row_max_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pool_defs.svh"

// Holds the horizontal pair maxima of the even row until the odd row
// below reaches the same pooled column.
module row_max_buffer (
    input  wire logic               clk,
    input  wire logic               rst_n,

    input  wire logic               write_en,
    input  wire pool_pkg::buf_idx_t index,
    input  wire pool_pkg::pixel_t   wr_pixel,
    output pool_pkg::pixel_t        rd_pixel
);

    import pool_pkg::*;

    localparam int DEPTH = `POOL_MAP_WIDTH / 2;

    pixel_t mem [DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (write_en) begin
            mem[index] <= wr_pixel;
        end
    end

    // Read is combinational so the window closes in the cycle of its last pixel.
    assign rd_pixel = mem[index];

endmodule

`default_nettype wire

// ==== src/window_max.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pool_defs.svh"

// Left pixel of the current pair, plus the two compare stages of the window.
module window_max (
    input  wire logic             clk,
    input  wire logic             rst_n,

    input  wire logic             hold,
    input  wire pool_pkg::pixel_t cur_pixel,
    input  wire pool_pkg::pixel_t above_pixel,
    output pool_pkg::pixel_t      pair_max,
    output pool_pkg::pixel_t      window_max
);

    import pool_pkg::*;

    pixel_t left_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            left_q <= '0;
        end else if (hold) begin
            left_q <= cur_pixel;
        end
    end

    always_comb begin
        for (int c = 0; c < `POOL_CHANNELS; c++) begin
            pair_max.ch[c] = (cur_pixel.ch[c] > left_q.ch[c]) ? cur_pixel.ch[c]
                                                               : left_q.ch[c];
        end
    end

    // The upper pair was reduced a row earlier and waits in the line buffer.
    always_comb begin
        for (int c = 0; c < `POOL_CHANNELS; c++) begin
            window_max.ch[c] = (above_pixel.ch[c] > pair_max.ch[c]) ? above_pixel.ch[c]
                                                                    : pair_max.ch[c];
        end
    end

endmodule

`default_nettype wire

// ==== src/pool_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// ReLU and 2x2 stride-2 max pooling on a raster stream of pixels.
module pool_top (
    input  wire logic                 clk,
    input  wire logic                 rst_n,

    input  wire logic                 in_valid,
    output logic                      in_ready,
    input  wire pool_pkg::raw_pixel_t in_data,

    output logic                      out_valid,
    input  wire logic                 out_ready,
    output pool_pkg::pooled_t         out_data
);

    import pool_pkg::*;

    logic       pix_valid;
    raw_pixel_t raw_pix;
    pixel_t     relu_pix;
    logic       take;
    logic       hold_pair;
    logic       write_row;
    logic       emit;
    logic       last;
    logic       emit_ready;
    buf_idx_t   col_index;
    pixel_t     above_max;
    pixel_t     pair_max;
    pixel_t     win_max;
    pooled_t    pooled;

    assign pooled.last = last;
    assign pooled.pix  = win_max;

    stream_reg #(.payload_t(raw_pixel_t)) in_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (pix_valid),
        .out_ready (take),
        .out_data  (raw_pix)
    );

    relu_clamp u_relu (
        .in_pixel  (raw_pix),
        .out_pixel (relu_pix)
    );

    pool_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_valid (pix_valid),
        .out_ready (emit_ready),
        .take      (take),
        .hold_pair (hold_pair),
        .write_row (write_row),
        .emit      (emit),
        .last      (last),
        .col_index (col_index)
    );

    row_max_buffer u_row_buf (
        .clk      (clk),
        .rst_n    (rst_n),
        .write_en (write_row),
        .index    (col_index),
        .wr_pixel (pair_max),
        .rd_pixel (above_max)
    );

    window_max u_win (
        .clk         (clk),
        .rst_n       (rst_n),
        .hold        (hold_pair),
        .cur_pixel   (relu_pix),
        .above_pixel (above_max),
        .pair_max    (pair_max),
        .window_max  (win_max)
    );

    stream_reg #(.payload_t(pooled_t)) out_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (emit),
        .in_ready  (emit_ready),
        .in_data   (pooled),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

// ==== tb/tb_pool_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pool_defs.svh"

module tb_pool_top;

    import pool_pkg::*;

    localparam int W          = `POOL_MAP_WIDTH;
    localparam int H          = `POOL_MAP_HEIGHT;
    localparam int NCH        = `POOL_CHANNELS;
    localparam int NPIX       = W * H;
    localparam int NWIN       = (W / 2) * (H / 2);
    localparam int WAIT_LIMIT = 200;  // Cycles that any single wait may take.

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    logic       in_ready;
    raw_pixel_t in_data;
    logic       out_valid;
    logic       out_ready;
    pooled_t    out_data;

    raw_pixel_t cur_map [NPIX];
    pooled_t    exp_q [$];
    int         rise_q [$];         // Cycle of every rising edge of out_valid.

    int cycle        = 0;
    int errors       = 0;
    int mon_errors   = 0;
    int out_count    = 0;
    int tests_run    = 0;
    int start_errors = 0;
    int start_outs   = 0;
    int br_cycle     = 0;           // Transfer of the first window's bottom-right pixel.
    bit valid_prev   = 1'b0;
    bit stalled      = 1'b0;
    bit backpressure = 1'b0;

    pool_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Downstream consumer. Ready is random while back-pressure is on.
    always @(posedge clk) begin
        #1;
        if (backpressure) begin
            out_ready = ($urandom % 100) >= 45;
        end else begin
            out_ready = 1'b1;
        end
    end

    always @(posedge clk) begin : monitor
        pooled_t want;
        if (rst_n) begin
            if (out_valid && !valid_prev) begin
                rise_q.push_back(cycle);
            end
            valid_prev = out_valid;
            if (out_valid && out_ready) begin
                out_count++;
                assert (exp_q.size() > 0) else begin
                    mon_errors++;
                    $display("An output arrived at %0t when none was expected.", $time);
                end
                if (exp_q.size() > 0) begin
                    want = exp_q.pop_front();
                    assert (out_data == want) else begin
                        mon_errors++;
                        $display("ERR %0t: output %0d is %h, expected %h",
                                 $time, out_count, out_data, want);
                    end
                end
            end
        end
    end

    function automatic activ_t relu(sactiv_t v);
        return (v < 0) ? activ_t'(0) : activ_t'(v);
    endfunction

    // Reference model over the whole stored map.
    task automatic queue_expected();
        pooled_t p;
        activ_t  m;
        activ_t  v;
        for (int oy = 0; oy < H / 2; oy++) begin
            for (int ox = 0; ox < W / 2; ox++) begin
                for (int c = 0; c < NCH; c++) begin
                    m = '0;
                    for (int dy = 0; dy < 2; dy++) begin
                        for (int dx = 0; dx < 2; dx++) begin
                            v = relu(cur_map[(2 * oy + dy) * W + 2 * ox + dx].ch[c]);
                            if (v > m) m = v;
                        end
                    end
                    p.pix.ch[c] = m;
                end
                p.last = (oy == H / 2 - 1) && (ox == W / 2 - 1);
                exp_q.push_back(p);
            end
        end
    endtask

    task automatic fill_ramp();
        for (int i = 0; i < NPIX; i++) begin
            for (int c = 0; c < NCH; c++) begin
                cur_map[i].ch[c] = sactiv_t'(((i * 7 + c * 13) % 120) + 1);
            end
        end
    endtask

    // Channel 0 always negative, channel 2 negative on the upper rows.
    task automatic fill_signed();
        int x;
        int y;
        for (int i = 0; i < NPIX; i++) begin
            x = i % W;
            y = i / W;
            cur_map[i].ch[0] = sactiv_t'(-1 - i);
            cur_map[i].ch[1] = sactiv_t'(((x + y) % 2 == 0) ? -(i + 5) : i * 3);
            cur_map[i].ch[2] = sactiv_t'((y < H / 2) ? -100 + i : i);
            cur_map[i].ch[3] = sactiv_t'((x == W - 1 && y == H - 1) ? 127 : -128 + i);
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < NPIX; i++) begin
            for (int c = 0; c < NCH; c++) begin
                cur_map[i].ch[c] = sactiv_t'($urandom);
            end
        end
    endtask

    task automatic send_pixel(raw_pixel_t p, int idx);
        int waited;
        waited   = 0;
        in_valid = 1'b1;
        in_data  = p;
        do begin
            @(posedge clk);
            waited++;
        end while (!in_ready && waited < WAIT_LIMIT);
        if (in_ready) begin
            if (idx == W + 1) br_cycle = cycle;
        end else begin
            stalled = 1'b1;
            errors++;
            $display("Input stalled: pixel %0d was not accepted in %0d cycles.",
                     idx, WAIT_LIMIT);
        end
        #1;
        in_valid = 1'b0;
    endtask

    task automatic send_map(int gap_pct);
        int gap;
        for (int i = 0; i < NPIX && !stalled; i++) begin
            if (($urandom % 100) < gap_pct) begin
                gap = int'($urandom % 3) + 1;
                repeat (gap) @(posedge clk);
                #1;
            end
            send_pixel(cur_map[i], i);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() > 0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_q.size() > 0) begin
            stalled = 1'b1;
            errors++;
            $display("Output stalled: %0d pooled pixels still missing after %0d cycles.",
                     exp_q.size(), WAIT_LIMIT);
        end
        repeat (4) @(posedge clk);  // Room for any extra output to show up.
        #1;
    endtask

    task automatic begin_test();
        start_errors = errors + mon_errors;
        start_outs   = out_count;
    endtask

    task automatic end_test(string name, int maps);
        assert (out_count - start_outs == maps * NWIN) else begin
            errors++;
            $display("ERR %0t: %s gave %0d outputs, expected %0d",
                     $time, name, out_count - start_outs, maps * NWIN);
        end
        tests_run++;
        $display("%s: %0d outputs, %0d errors", name, out_count - start_outs,
                 errors + mon_errors - start_errors);
    endtask

    task automatic test_positive_map();
        begin_test();
        fill_ramp();
        queue_expected();
        send_map(0);
        wait_drain();
        end_test("positive_map", 1);
    endtask

    task automatic test_signed_map();
        begin_test();
        fill_signed();
        queue_expected();
        send_map(0);
        wait_drain();
        end_test("signed_map", 1);
    endtask

    task automatic test_input_gaps();
        begin_test();
        fill_random();
        queue_expected();
        send_map(35);
        wait_drain();
        end_test("input_gaps", 1);
    endtask

    task automatic test_backpressure();
        begin_test();
        backpressure = 1'b1;
        fill_random();
        queue_expected();
        send_map(20);
        wait_drain();
        backpressure = 1'b0;
        end_test("backpressure", 1);
    endtask

    task automatic test_two_maps();
        begin_test();
        fill_random();
        queue_expected();
        send_map(0);
        fill_signed();
        queue_expected();
        send_map(0);
        wait_drain();
        end_test("two_maps", 2);
    endtask

    task automatic test_latency();
        int first_rise;
        begin_test();
        backpressure = 1'b0;
        @(posedge clk);
        #1;
        first_rise = rise_q.size();
        fill_random();
        queue_expected();
        send_map(0);
        wait_drain();
        assert (rise_q.size() > first_rise && rise_q[first_rise] - br_cycle == 2) else begin
            errors++;
            $display("ERR %0t: first output not valid 2 cycles after its last input", $time);
        end
        end_test("latency", 1);
    endtask

    initial begin
        void'($urandom(32'h869a));
        clk       = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        assert (in_ready && !out_valid) else begin
            errors++;
            $display("Wrong handshake state after reset: in_ready low or out_valid high.");
        end
        if (!stalled) test_latency();
        if (!stalled) test_positive_map();
        if (!stalled) test_signed_map();
        if (!stalled) test_input_gaps();
        if (!stalled) test_backpressure();
        if (!stalled) test_two_maps();
        $display("Tests run: %0d, errors: %0d", tests_run, errors + mon_errors);
        if (errors + mon_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== pool_layer.f ====
+incdir+src
src/pool_pkg.sv
src/stream_reg.sv
src/relu_clamp.sv
src/pool_ctrl.sv
src/row_max_buffer.sv
src/window_max.sv
src/pool_top.sv
tb/tb_pool_top.sv

// ==== Makefile ====
SOURCES := $(wildcard src/*.sv src/*.svh tb/*.sv)

obj_dir/Vtb_pool_top: pool_layer.f $(SOURCES)
	verilator --binary --timing --assert -f pool_layer.f --top-module tb_pool_top

.PHONY: run clean

run: obj_dir/Vtb_pool_top
	@out="$$(./obj_dir/Vtb_pool_top)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
